// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= pet_game_tb
FILELIST ?= pet_game.f
VFLAGS ?= --binary --assert --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// ==== hw/pet_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

// game state machine
// strobes are combinational
// the counters take them on the edge that leaves the state
module pet_fsm import pet_pkg::*; (
	input logic frame_clk,
	input logic reset,
	input key_t key,
	input logic all_healthy,
	input logic any_zero,
	input logic fullness_high,
	input logic affection_high,
	output logic [NUM_VITALS-1:0] vital_load,
	output logic [NUM_VITALS-1:0] vital_inc,
	output logic [NUM_VITALS-1:0] vital_dec,
	output sprite_t sprite,
	output pet_state_t game_state
);

	pet_state_t state, state_next;
	// idle animation step, 1..8
	logic [3:0] idle_step, step_next;
	dwell_t dwell, dwell_next;

	logic dwell_done;
	logic hit_feed, hit_pet, hit_restart;

	// --------------------------------------------------
	// key match and dwell end
	// --------------------------------------------------

	assign hit_feed = (key == KEY_FEED);
	assign hit_pet = (key == KEY_PET);
	assign hit_restart = (key == KEY_RESTART);

	// last frame of a timed state
	assign dwell_done = (dwell == DWELL_FRAMES - 5'd1);

	// --------------------------------------------------
	// next state and strobes
	// --------------------------------------------------

	always_comb begin
		state_next = state;
		step_next = idle_step;
		// untimed states keep the count at zero
		dwell_next = '0;
		vital_load = '0;
		vital_inc = '0;
		vital_dec = '0;

		unique case (state)
			st_start: begin
				vital_load = '1;
				state_next = st_check;
			end
			st_check: begin
				// happy wins, then death, else sad
				if (all_healthy)
					state_next = st_idle_happy;
				else if (any_zero)
					state_next = st_dead;
				else
					state_next = st_idle_sad;
				step_next = 4'd1;
			end
			st_idle_happy, st_idle_sad: begin
				dwell_next = dwell + 5'd1;
				if (hit_feed) begin
					state_next = st_feed;
				end else if (hit_pet) begin
					state_next = st_pet;
				end else if (dwell_done) begin
					// full pass costs one point of each vital
					if (idle_step == 4'(IDLE_STEPS)) begin
						vital_dec = '1;
						state_next = st_check;
					end else begin
						step_next = idle_step + 4'd1;
					end
				end
			end
			st_feed: begin
				// keys ignored while eating
				dwell_next = dwell + 5'd1;
				if (dwell_done) begin
					if (fullness_high) begin
						vital_dec[vi_health] = 1'b1;
						state_next = st_upset;
					end else begin
						vital_inc[vi_health] = 1'b1;
						vital_inc[vi_fullness] = 1'b1;
						state_next = st_feed_done;
					end
				end
			end
			st_pet: begin
				dwell_next = dwell + 5'd1;
				if (dwell_done) begin
					if (affection_high) begin
						vital_dec[vi_health] = 1'b1;
						state_next = st_upset;
					end else begin
						vital_inc[vi_health] = 1'b1;
						vital_inc[vi_affection] = 1'b1;
						state_next = st_pet_done;
					end
				end
			end
			st_feed_done, st_upset: begin
				// feed and pet keys interrupt as in idle
				dwell_next = dwell + 5'd1;
				if (hit_feed)
					state_next = st_feed;
				else if (hit_pet)
					state_next = st_pet;
				else if (dwell_done)
					state_next = st_check;
			end
			st_pet_done: begin
				dwell_next = dwell + 5'd1;
				if (dwell_done)
					state_next = st_check;
			end
			st_dead: begin
				// waits here until restart
				if (hit_restart)
					state_next = st_start;
			end
			default: state_next = st_start;
		endcase

		// fresh count on any state or step change
		if (state_next != state || step_next != idle_step)
			dwell_next = '0;
	end

	// --------------------------------------------------
	// registers
	// --------------------------------------------------

	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset) begin
			state <= st_start;
			idle_step <= 4'd1;
			dwell <= '0;
		end else begin
			state <= state_next;
			idle_step <= step_next;
			dwell <= dwell_next;
		end
	end

	// --------------------------------------------------
	// sprite lookup
	// --------------------------------------------------

	always_comb begin
		unique case (state)
			st_idle_happy: sprite = SPR_IDLE_HAPPY_BASE + sprite_t'(idle_step);
			st_idle_sad: sprite = SPR_IDLE_SAD_BASE + sprite_t'(idle_step);
			st_feed_done: sprite = SPR_FEED_DONE;
			st_pet_done: sprite = SPR_PET_DONE;
			st_upset, st_dead: sprite = SPR_SAD;
			default: sprite = SPR_NEUTRAL;
		endcase
	end

	assign game_state = state;

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// a counter never sees both directions in one frame
	a_inc_dec_excl: assert property (@(posedge frame_clk) disable iff (reset)
		(vital_inc & vital_dec) == '0)
		else $error("inc and dec together: %b %b", vital_inc, vital_dec);

	// dwell is cleared before it runs past one period
	a_dwell_bound: assert property (@(posedge frame_clk) disable iff (reset)
		dwell <= DWELL_FRAMES)
		else $error("dwell overran: %0d", dwell);

endmodule

`default_nettype wire

// ==== hw/pet_game.sv ====
`timescale 1ns/1ps
`default_nettype none

// virtual pet top
// fsm drives three vital counters
// monitor feeds their status back
module pet_game import pet_pkg::*; (
	input logic frame_clk,
	input logic reset,
	input key_t key,
	output sprite_t sprite,
	output pet_state_t game_state,
	output vital_t health,
	output vital_t fullness,
	output vital_t affection
);

	// per-vital strobes from the fsm
	logic [NUM_VITALS-1:0] vital_load;
	logic [NUM_VITALS-1:0] vital_inc;
	logic [NUM_VITALS-1:0] vital_dec;

	// counter values indexed by vital_idx_t
	vital_t vitals [NUM_VITALS];

	// monitor flags back to the fsm
	logic all_healthy, any_zero, fullness_high, affection_high;

	// --------------------------------------------------
	// game control
	// --------------------------------------------------

	pet_fsm u_fsm (
		.frame_clk (frame_clk),
		.reset (reset),
		.key (key),
		.all_healthy (all_healthy),
		.any_zero (any_zero),
		.fullness_high (fullness_high),
		.affection_high (affection_high),
		.vital_load (vital_load),
		.vital_inc (vital_inc),
		.vital_dec (vital_dec),
		.sprite (sprite),
		.game_state (game_state)
	);

	// --------------------------------------------------
	// vitals
	// --------------------------------------------------

	// one counter per slot
	// health first
	for (genvar i = vi_health; i <= vi_affection; i++) begin : g_vital
		vital_counter u_vital (
			.frame_clk (frame_clk),
			.reset (reset),
			.load (vital_load[i]),
			.inc (vital_inc[i]),
			.dec (vital_dec[i]),
			.value (vitals[i])
		);
	end

	assign health = vitals[vi_health];
	assign fullness = vitals[vi_fullness];
	assign affection = vitals[vi_affection];

	vitals_monitor u_monitor (
		.health (health),
		.fullness (fullness),
		.affection (affection),
		.all_healthy (all_healthy),
		.any_zero (any_zero),
		.fullness_high (fullness_high),
		.affection_high (affection_high)
	);

endmodule

`default_nettype wire

// ==== hw/pet_pkg.sv ====
`default_nettype none

package pet_pkg;

	// --------------------------------------------------
	// value types
	// --------------------------------------------------

	// one vital, 0..15
	typedef logic [3:0] vital_t;
	// code sent to the sprite ROM on the display side
	typedef logic [7:0] sprite_t;
	// raw keyboard scan code
	typedef logic [7:0] key_t;
	// frame count inside a timed state
	typedef logic [4:0] dwell_t;

	// game phases
	// idle step number lives in its own register
	typedef enum logic [4:0] {
		st_start,
		st_check,
		st_idle_happy,
		st_idle_sad,
		st_feed,
		st_feed_done,
		st_pet,
		st_pet_done,
		st_upset,
		st_dead
	} pet_state_t;

	// slot of each vital in the strobe vectors
	typedef enum logic [1:0] {
		vi_health,
		vi_fullness,
		vi_affection
	} vital_idx_t;

	// --------------------------------------------------
	// game constants
	// --------------------------------------------------

	localparam int NUM_VITALS = 3;

	// vital range and thresholds
	localparam vital_t VITAL_INIT = 4'd5;
	localparam vital_t VITAL_MAX = 4'd15;
	localparam vital_t HAPPY_MIN = 4'd5;
	// shared limit for fullness and affection
	localparam vital_t SATED_MAX = 4'd9;

	// timing, in frames
	localparam dwell_t DWELL_FRAMES = 5'd21;
	localparam int IDLE_STEPS = 8;

	// scan codes
	localparam key_t KEY_FEED = 8'h14;
	localparam key_t KEY_PET = 8'h1a;
	localparam key_t KEY_RESTART = 8'h16;

	// sprite codes
	localparam sprite_t SPR_NEUTRAL = 8'h00;
	localparam sprite_t SPR_SAD = 8'h01;
	localparam sprite_t SPR_IDLE_HAPPY_BASE = 8'ha0;
	localparam sprite_t SPR_IDLE_SAD_BASE = 8'hb0;
	localparam sprite_t SPR_FEED_DONE = 8'hc1;
	localparam sprite_t SPR_PET_DONE = 8'hd1;

endpackage

`default_nettype wire

// ==== hw/vital_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

// one saturating vital
// load wins over inc and dec
module vital_counter import pet_pkg::*; (
	input logic frame_clk,
	input logic reset,
	input logic load,
	input logic inc,
	input logic dec,
	output vital_t value
);

	// --------------------------------------------------
	// counter register
	// --------------------------------------------------

	always_ff @(posedge frame_clk or posedge reset) begin
		if (reset) begin
			// every vital starts at the same level
			value <= VITAL_INIT;
		end else if (load) begin
			// restart path from the fsm
			value <= VITAL_INIT;
		end else if (inc) begin
			// clamp at the top
			if (value != VITAL_MAX)
				value <= value + 4'd1;
		end else if (dec) begin
			// clamp at zero
			// death is decided elsewhere
			if (value != '0)
				value <= value - 4'd1;
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// range stays inside the game limits
	a_value_range: assert property (@(posedge frame_clk) disable iff (reset)
		value <= VITAL_MAX)
		else $error("vital above VITAL_MAX: %0h", value);

endmodule

`default_nettype wire

// ==== hw/vitals_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

// game-level flags from the three vitals
// purely combinational
// read back by the fsm
module vitals_monitor import pet_pkg::*; (
	input vital_t health,
	input vital_t fullness,
	input vital_t affection,
	output logic all_healthy,
	output logic any_zero,
	output logic fullness_high,
	output logic affection_high
);

	// --------------------------------------------------
	// status flags
	// --------------------------------------------------

	// happy idle needs every vital at or above the bar
	assign all_healthy = (health >= HAPPY_MIN)
		&& (fullness >= HAPPY_MIN)
		&& (affection >= HAPPY_MIN);

	// one empty vital is enough to die
	assign any_zero = (health == '0)
		|| (fullness == '0)
		|| (affection == '0);

	// overfed means the next feed turns into upset
	assign fullness_high = fullness > SATED_MAX;

	// same limit on affection for pet
	assign affection_high = affection > SATED_MAX;

	// --------------------------------------------------
	// checks
	// --------------------------------------------------

	// check state relies on these two being exclusive
	// so the happy branch never hides a death
	always_comb begin
		a_healthy_vs_zero: assert final (!(all_healthy && any_zero))
			else $error("all_healthy and any_zero both set");
	end

endmodule

`default_nettype wire

// ==== pet_game.f ====
hw/pet_pkg.sv
hw/vital_counter.sv
hw/vitals_monitor.sv
hw/pet_fsm.sv
hw/pet_game.sv
testbench/pet_game_tb.sv

// ==== testbench/pet_game_input.txt ====
# columns: key hold sprite state health fullness affection
# hold is decimal cycles, all other columns hex
# start, check, then happy idle steps
00 2 a1 2 5 5 5
00 21 a2 2 5 5 5
# end of first idle pass, decay and sad idle
00 147 00 1 4 4 4
00 1 b1 3 4 4 4
# feed from sad idle
14 1 00 4 4 4 4
00 21 c1 5 5 5 4
00 21 00 1 5 5 4
00 1 b1 3 5 5 4
# pet, then back to happy idle
1a 1 00 6 5 5 4
00 21 d1 7 6 5 5
00 21 00 1 6 5 5
00 1 a1 2 6 5 5
# feed held down until overfed
14 22 c1 5 7 6 5
14 22 c1 5 8 7 5
14 22 c1 5 9 8 5
14 22 c1 5 a 9 5
14 22 c1 5 b a 5
14 22 01 8 a a 5
00 21 00 1 a a 5
00 1 a1 2 a a 5
# idle passes until affection runs out
00 169 b1 3 9 9 4
00 169 b1 3 8 8 3
00 169 b1 3 7 7 2
00 169 b1 3 6 6 1
00 169 01 9 5 5 0
00 50 01 9 5 5 0
# restart from dead
16 1 00 0 5 5 0
00 1 00 1 5 5 5
00 1 a1 2 5 5 5

// ==== testbench/pet_game_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pet_game_tb import pet_pkg::*; ;

	localparam int MAX_STEPS = 64;
	localparam int RESET_CYCLES = 16;
	localparam int SLACK_CYCLES = 200;
	localparam int CLK_PERIOD = 100;

	logic frame_clk;
	logic reset;
	key_t key;
	sprite_t sprite;
	pet_state_t game_state;
	vital_t health;
	vital_t fullness;
	vital_t affection;

	// one entry per data line of the stimulus file
	key_t step_key [MAX_STEPS];
	int step_hold [MAX_STEPS];
	logic [7:0] exp_sprite [MAX_STEPS];
	logic [7:0] exp_state [MAX_STEPS];
	logic [7:0] exp_health [MAX_STEPS];
	logic [7:0] exp_fullness [MAX_STEPS];
	logic [7:0] exp_affection [MAX_STEPS];

	int num_steps;
	int total_hold;
	logic file_ok;
	logic loaded;

	pet_game uut (
		.frame_clk (frame_clk),
		.reset (reset),
		.key (key),
		.sprite (sprite),
		.game_state (game_state),
		.health (health),
		.fullness (fullness),
		.affection (affection)
	);

	// 100 ns frame clock
	always #(CLK_PERIOD / 2) frame_clk = ~frame_clk;

	// --------------------------------------------------
	// stimulus file
	// --------------------------------------------------

	task automatic load_steps();
		int fd;
		int n;
		int k, h, s, st, hv, fv, av;
		string line;
		num_steps = 0;
		total_hold = 0;
		fd = $fopen("testbench/pet_game_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/pet_game_input.txt");
			file_ok = 1'b0;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// skip blank lines and # comments
				if (line.len() > 1 && line.getc(0) != 8'h23) begin
					n = $sscanf(line, "%h %d %h %h %h %h %h", k, h, s, st, hv, fv, av);
					if (n != 7 || num_steps >= MAX_STEPS) begin
						$display("bad or surplus line in stimulus file: %s", line);
						file_ok = 1'b0;
					end else begin
						step_key[num_steps] = key_t'(k);
						step_hold[num_steps] = h;
						exp_sprite[num_steps] = 8'(s);
						exp_state[num_steps] = 8'(st);
						exp_health[num_steps] = 8'(hv);
						exp_fullness[num_steps] = 8'(fv);
						exp_affection[num_steps] = 8'(av);
						total_hold += h;
						num_steps++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	// --------------------------------------------------
	// checks and steps
	// --------------------------------------------------

	task automatic check_value(input string name, input logic [7:0] got,
		input logic [7:0] exp, input int idx);
		assert (got === exp)
		else begin
			$display("MISMATCH %s at step %0d: got %h expected %h", name, idx, got, exp);
			$display("TB FAILED");
			$fatal(1, "output check failed");
		end
	endtask

	// key changes on the falling edge
	// outputs compared on a later falling edge
	task automatic run_step(input int idx);
		key = step_key[idx];
		repeat (step_hold[idx]) @(negedge frame_clk);
		check_value("sprite", sprite, exp_sprite[idx], idx);
		check_value("game_state", 8'(game_state), exp_state[idx], idx);
		check_value("health", 8'(health), exp_health[idx], idx);
		check_value("fullness", 8'(fullness), exp_fullness[idx], idx);
		check_value("affection", 8'(affection), exp_affection[idx], idx);
	endtask

	// --------------------------------------------------
	// main sequence
	// --------------------------------------------------

	initial begin
		frame_clk = 1'b0;
		reset = 1'b1;
		key = '0;
		loaded = 1'b0;
		file_ok = 1'b1;
		load_steps();
		loaded = 1'b1;
		if (!file_ok || num_steps == 0) begin
			$display("stimulus file missing, malformed or empty");
			$display("TB FAILED");
			$fatal(1, "no valid stimulus");
		end else begin
			repeat (RESET_CYCLES) @(negedge frame_clk);
			reset = 1'b0;
			for (int i = 0; i < num_steps; i++)
				run_step(i);
			$display("TB PASSED");
			$finish;
		end
	end

	// watchdog sized from the file's hold cycles
	initial begin
		wait (loaded);
		#(longint'(total_hold + RESET_CYCLES + SLACK_CYCLES) * CLK_PERIOD);
		$display("timeout: test did not finish within %0d cycles",
			total_hold + RESET_CYCLES + SLACK_CYCLES);
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire
